//--- include/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Datapath width of the RV32I core
`define XLEN 32

// Architectural registers, x0 included
`define NUM_REGS 32
`define REG_ADDR_W 5

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

// Fixed-length 32-bit encodings, no compressed set
`define INSN_BYTES 4

`endif

//--- verilog/rv_pkg.sv
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // Major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_OP       = 7'b011_0011,
    OPC_OP_IMM   = 7'b001_0011,
    OPC_LUI      = 7'b011_0111,
    OPC_AUIPC    = 7'b001_0111,
    OPC_BRANCH   = 7'b110_0011,
    OPC_JAL      = 7'b110_1111,
    OPC_JALR     = 7'b110_0111,
    OPC_MISC_MEM = 7'b000_1111,  // FENCE
    OPC_SYSTEM   = 7'b111_0011   // ECALL
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B,  // LUI
    ALU_ADD_PC   // AUIPC
  } alu_op_e;

  typedef enum logic [2:0] {
    CLS_ALU,
    CLS_BRANCH,
    CLS_JAL,
    CLS_JALR,
    CLS_NOP,
    CLS_HALT,
    CLS_ILLEGAL
  } insn_class_e;

  typedef struct packed {
    insn_class_e insn_class;
    alu_op_e     alu_op;
    logic        use_imm;    // Operand B from imm instead of rs2
    logic [2:0]  funct3;     // Branch condition select
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    word_t       imm;        // Already sign-extended for the format
    logic        writes_rd;
  } decoded_insn_t;

endpackage

`default_nettype wire

//--- verilog/exec_if.sv
`default_nettype none
`timescale 1ns/100ps

interface exec_if (
  input logic clk,
  input logic rst
);
  import rv_pkg::*;

  word_t         pc;       // PC of the instruction in EXEC
  decoded_insn_t op;
  word_t         rs1_val;
  word_t         rs2_val;

  modport dec (output op);
  modport rf  (input clk, rst, op, output rs1_val, rs2_val);
  modport seq (input clk, rst, op, output pc);
  modport alu (input pc, op, rs1_val, rs2_val);
  modport br  (input pc, op, rs1_val, rs2_val);

endinterface

`default_nettype wire

//--- verilog/insn_decoder.sv
`default_nettype none
`timescale 1ns/100ps

module insn_decoder (
  input  rv_pkg::word_t insn,
  exec_if.dec           x
);
  import rv_pkg::*;

  opcode_e       opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  logic          f7_zero;  // Base encoding
  logic          f7_alt;   // SUB, SRA, SRAI
  word_t         imm_i;
  word_t         imm_b;
  word_t         imm_j;
  word_t         imm_u;
  decoded_insn_t dec;

  // funct3 to ALU op, shared by OP and OP_IMM
  function automatic alu_op_e base_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  base_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  base_op = ALU_SLL;
      3'b010:  base_op = ALU_SLT;
      3'b011:  base_op = ALU_SLTU;
      3'b100:  base_op = ALU_XOR;
      3'b101:  base_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  base_op = ALU_OR;
      default: base_op = ALU_AND;
    endcase
  endfunction

  assign opcode  = opcode_e'(insn[6:0]);
  assign funct3  = insn[14:12];
  assign funct7  = insn[31:25];
  assign f7_zero = (funct7 == 7'b000_0000);
  assign f7_alt  = (funct7 == 7'b010_0000);

  // Immediates, sign bit always insn[31]
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    dec            = '0;
    dec.insn_class = CLS_ILLEGAL;  // Until an opcode below claims it
    dec.alu_op     = base_op(funct3, f7_alt);
    dec.funct3     = funct3;
    dec.rs1        = insn[19:15];
    dec.rs2        = insn[24:20];
    dec.rd         = insn[11:7];
    case (opcode)
      OPC_OP: begin
        if (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          dec.insn_class = CLS_ALU;
          dec.writes_rd  = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        dec.alu_op  = base_op(funct3, f7_alt && funct3 == 3'b101);  // No SUBI
        dec.use_imm = 1'b1;
        dec.imm     = imm_i;
        // Only the shifts care about the upper imm bits
        if ((funct3 != 3'b001 && funct3 != 3'b101) || f7_zero ||
            (f7_alt && funct3 == 3'b101)) begin
          dec.insn_class = CLS_ALU;
          dec.writes_rd  = 1'b1;
        end
      end
      OPC_LUI, OPC_AUIPC: begin
        dec.insn_class = CLS_ALU;
        dec.alu_op     = (opcode == OPC_LUI) ? ALU_PASS_B : ALU_ADD_PC;
        dec.use_imm    = 1'b1;
        dec.imm        = imm_u;
        dec.writes_rd  = 1'b1;
      end
      OPC_BRANCH: begin
        if (funct3[2:1] != 2'b01) begin  // 010 and 011 unused
          dec.insn_class = CLS_BRANCH;
          dec.imm        = imm_b;
        end
      end
      OPC_JAL: begin
        dec.insn_class = CLS_JAL;
        dec.imm        = imm_j;
        dec.writes_rd  = 1'b1;
      end
      OPC_JALR: begin
        dec.insn_class = CLS_JALR;
        dec.imm        = imm_i;
        dec.writes_rd  = 1'b1;
      end
      OPC_MISC_MEM: dec.insn_class = CLS_NOP;  // FENCE, nothing to order
      OPC_SYSTEM: begin
        if (insn[31:7] == 25'd0) begin  // ECALL only
          dec.insn_class = CLS_HALT;
        end
      end
      default: ;
    endcase
  end

  assign x.op = dec;

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`default_nettype none
`timescale 1ns/100ps

`include "rv_defs.svh"

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  rv_pkg::reg_addr_t waddr,
  input  rv_pkg::word_t     wdata,
  exec_if.rf                x
);
  import rv_pkg::*;

  word_t regs [1:`NUM_REGS-1];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;  // Writes to x0 are dropped
    end
  end

  // Combinational reads
  assign x.rs1_val = (x.op.rs1 == '0) ? '0 : regs[x.op.rs1];
  assign x.rs2_val = (x.op.rs2 == '0) ? '0 : regs[x.op.rs2];

endmodule

`default_nettype wire

//--- verilog/int_alu.sv
`default_nettype none
`timescale 1ns/100ps

module int_alu (
  exec_if.alu           x,
  output rv_pkg::word_t result
);
  import rv_pkg::*;

  word_t      op_b;
  logic [4:0] shamt;

  assign op_b  = x.op.use_imm ? x.op.imm : x.rs2_val;
  assign shamt = op_b[4:0];  // rs2[4:0] or the shamt field of the imm

  always_comb begin
    case (x.op.alu_op)
      ALU_ADD:    result = x.rs1_val + op_b;
      ALU_SUB:    result = x.rs1_val - op_b;
      ALU_SLL:    result = x.rs1_val << shamt;
      ALU_SLT:    result = word_t'($signed(x.rs1_val) < $signed(op_b));
      ALU_SLTU:   result = word_t'(x.rs1_val < op_b);
      ALU_XOR:    result = x.rs1_val ^ op_b;
      ALU_SRL:    result = x.rs1_val >> shamt;
      ALU_SRA:    result = word_t'($signed(x.rs1_val) >>> shamt);
      ALU_OR:     result = x.rs1_val | op_b;
      ALU_AND:    result = x.rs1_val & op_b;
      ALU_PASS_B: result = op_b;          // LUI, imm already shifted
      ALU_ADD_PC: result = x.pc + op_b;   // AUIPC
      default:    result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/branch_unit.sv
`default_nettype none
`timescale 1ns/100ps

`include "rv_defs.svh"

module branch_unit (
  exec_if.br            x,
  output logic          taken,
  output rv_pkg::word_t target,
  output rv_pkg::word_t link
);
  import rv_pkg::*;

  logic  cond;
  word_t jalr_sum;

  // Branch condition by funct3
  always_comb begin
    case (x.op.funct3)
      3'b000:  cond = (x.rs1_val == x.rs2_val);                   // BEQ
      3'b001:  cond = (x.rs1_val != x.rs2_val);                   // BNE
      3'b100:  cond = ($signed(x.rs1_val) < $signed(x.rs2_val));  // BLT
      3'b101:  cond = ($signed(x.rs1_val) >= $signed(x.rs2_val)); // BGE
      3'b110:  cond = (x.rs1_val < x.rs2_val);                    // BLTU
      default: cond = (x.rs1_val >= x.rs2_val);                   // BGEU
    endcase
  end

  assign taken = (x.op.insn_class == CLS_JAL) ||
                 (x.op.insn_class == CLS_JALR) ||
                 (x.op.insn_class == CLS_BRANCH && cond);

  assign jalr_sum = x.rs1_val + x.op.imm;

  // JALR drops bit 0 of the sum
  assign target = (x.op.insn_class == CLS_JALR) ? {jalr_sum[`XLEN-1:1], 1'b0}
                                                : x.pc + x.op.imm;

  assign link = x.pc + `INSN_BYTES;

endmodule

`default_nettype wire

//--- verilog/sequencer.sv
`default_nettype none
`timescale 1ns/100ps

`include "rv_defs.svh"

module sequencer (
  input  logic              clk,
  input  logic              rst,
  output logic              fetch_req,
  output rv_pkg::word_t     fetch_addr,
  input  logic              fetch_ack,
  input  rv_pkg::word_t     fetch_insn,
  output rv_pkg::word_t     insn,
  exec_if.seq               x,
  input  rv_pkg::word_t     alu_result,
  input  logic              br_taken,
  input  rv_pkg::word_t     br_target,
  input  rv_pkg::word_t     br_link,
  output logic              rf_we,
  output rv_pkg::reg_addr_t rf_waddr,
  output rv_pkg::word_t     rf_wdata,
  output logic              commit_valid,
  output rv_pkg::word_t     commit_pc,
  output logic              commit_we,
  output rv_pkg::reg_addr_t commit_rd,
  output rv_pkg::word_t     commit_data,
  output logic              halt,
  output logic              illegal_insn
);
  import rv_pkg::*;

  typedef enum logic [1:0] {S_REQ, S_RELEASE, S_EXEC, S_STOPPED} state_e;

  state_e state;
  word_t  pc;
  word_t  insn_q;
  word_t  next_pc;
  logic   exec;
  logic   is_jump;
  logic   fetch_done;

  assign exec       = (state == S_EXEC);
  assign is_jump    = (x.op.insn_class == CLS_JAL) || (x.op.insn_class == CLS_JALR);
  assign fetch_done = (state == S_REQ) && fetch_req && fetch_ack;
  assign next_pc    = br_taken ? br_target : pc + `INSN_BYTES;

  assign fetch_addr = pc;  // Held for the whole of REQ
  assign x.pc       = pc;
  assign insn       = insn_q;

  // Register write, only during EXEC
  assign rf_we    = exec && x.op.writes_rd;
  assign rf_waddr = x.op.rd;
  assign rf_wdata = is_jump ? br_link : alu_result;

  // Retire trace
  assign commit_valid = exec;
  assign commit_pc    = pc;
  assign commit_we    = rf_we;
  assign commit_rd    = x.op.rd;
  assign commit_data  = rf_we ? rf_wdata : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= S_REQ;
      fetch_req    <= 1'b0;
      pc           <= `RESET_PC;
      halt         <= 1'b0;
      illegal_insn <= 1'b0;
    end else begin
      case (state)
        S_REQ: begin
          if (fetch_done) begin
            fetch_req <= 1'b0;
            state     <= S_RELEASE;
          end else begin
            fetch_req <= 1'b1;  // Also the first request after reset
          end
        end
        S_RELEASE: begin
          if (!fetch_ack) state <= S_EXEC;  // Source has dropped ack
        end
        S_EXEC: begin
          pc <= next_pc;
          case (x.op.insn_class)
            CLS_HALT: begin
              halt  <= 1'b1;
              state <= S_STOPPED;
            end
            CLS_ILLEGAL: begin
              halt         <= 1'b1;
              illegal_insn <= 1'b1;
              state        <= S_STOPPED;
            end
            default: begin
              fetch_req <= 1'b1;
              state     <= S_REQ;
            end
          endcase
        end
        default: ;  // Parked until reset
      endcase
    end
  end

  // Instruction register
  always_ff @(posedge clk) begin
    if (fetch_done) insn_q <= fetch_insn;
  end

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
`default_nettype none
`timescale 1ns/100ps

module rv_core (
  input  logic              clk,
  input  logic              rst,
  output logic              fetch_req,
  output rv_pkg::word_t     fetch_addr,
  input  logic              fetch_ack,
  input  rv_pkg::word_t     fetch_insn,
  output logic              commit_valid,
  output rv_pkg::word_t     commit_pc,
  output logic              commit_we,
  output rv_pkg::reg_addr_t commit_rd,
  output rv_pkg::word_t     commit_data,
  output logic              halt,
  output logic              illegal_insn
);
  import rv_pkg::*;

  word_t     insn;
  word_t     alu_result;
  logic      br_taken;
  word_t     br_target;
  word_t     br_link;
  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  exec_if ex_bus (.clk(clk), .rst(rst));

  insn_decoder u_decoder (.insn(insn), .x(ex_bus));

  reg_file u_regs (
    .clk   (clk),
    .rst   (rst),
    .we    (rf_we),
    .waddr (rf_waddr),
    .wdata (rf_wdata),
    .x     (ex_bus)
  );

  int_alu u_alu (.x(ex_bus), .result(alu_result));

  branch_unit u_branch (
    .x      (ex_bus),
    .taken  (br_taken),
    .target (br_target),
    .link   (br_link)
  );

  sequencer u_seq (
    .clk          (clk),
    .rst          (rst),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .fetch_ack    (fetch_ack),
    .fetch_insn   (fetch_insn),
    .insn         (insn),
    .x            (ex_bus),
    .alu_result   (alu_result),
    .br_taken     (br_taken),
    .br_target    (br_target),
    .br_link      (br_link),
    .rf_we        (rf_we),
    .rf_waddr     (rf_waddr),
    .rf_wdata     (rf_wdata),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_we    (commit_we),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data),
    .halt         (halt),
    .illegal_insn (illegal_insn)
  );

endmodule

`default_nettype wire

//--- testbench/tb_rv_core.sv
`default_nettype none
`timescale 1ns/100ps

`include "rv_defs.svh"

module tb_rv_core;
  import rv_pkg::*;

  localparam int IMEM_WORDS  = 64;
  localparam int CLK_PERIOD  = 10;
  localparam int WATCH_INSNS = 110;  // Retired instructions over all tests rounded up
  localparam int WATCH_CYCLES = WATCH_INSNS * 12 + 100;

  logic      clk;
  logic      rst;
  logic      fetch_req;
  word_t     fetch_addr;
  logic      fetch_ack;
  word_t     fetch_insn;
  logic      commit_valid;
  word_t     commit_pc;
  logic      commit_we;
  reg_addr_t commit_rd;
  word_t     commit_data;
  logic      halt;
  logic      illegal_insn;

  word_t imem [0:IMEM_WORDS-1];
  int    wp;          // Next word written by emit
  word_t mregs [0:31];  // Reference register file
  word_t mpc;
  word_t lfsr;
  logic  slow_src;    // Also delay the ack release
  string test_name;
  int    value_errs;
  int    proto_errs;
  logic  prev_req;
  logic  prev_ack;
  word_t prev_addr;

  rv_core DUT (
    .clk          (clk),
    .rst          (rst),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .fetch_ack    (fetch_ack),
    .fetch_insn   (fetch_insn),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_we    (commit_we),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data),
    .halt         (halt),
    .illegal_insn (illegal_insn)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Right-shift Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic word_t lfsr_step(input word_t s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Instruction source answering after 0 to 3 idle cycles
  initial begin
    int dly;
    fetch_ack  = 1'b0;
    fetch_insn = '0;
    forever begin
      @(posedge clk);
      #1;
      if (rst) begin
        fetch_ack = 1'b0;
      end else if (fetch_req && !fetch_ack) begin
        take_bits(2, dly);
        repeat (dly) begin
          @(posedge clk);
          #1;
        end
        fetch_insn = imem[fetch_addr[7:2]];
        fetch_ack  = 1'b1;
      end else if (fetch_ack && !fetch_req) begin
        if (slow_src) begin
          take_bits(2, dly);
          repeat (dly) begin
            @(posedge clk);
            #1;
          end
        end
        fetch_ack = 1'b0;
      end
    end
  end

  // Four-phase rule sampled mid-cycle
  initial begin
    prev_req  = 1'b0;
    prev_ack  = 1'b0;
    prev_addr = '0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (fetch_req && !prev_req && prev_ack) begin
          $display("Handshake error in %s: fetch_req rose while fetch_ack was still high",
                   test_name);
          proto_errs++;
        end
        if (fetch_req && prev_req && fetch_addr !== prev_addr) begin
          $display("Handshake error in %s: fetch_addr changed while fetch_req was high",
                   test_name);
          proto_errs++;
        end
      end
      prev_req  = fetch_req;
      prev_ack  = fetch_ack;
      prev_addr = fetch_addr;
    end
  end

  initial begin
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("Watchdog timeout in %s: the core stopped making progress", test_name);
    $display("Test failed");
    $finish;
  end

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_reg(input string what, input reg_addr_t exp, input reg_addr_t act);
    if (exp !== act) begin
      $display("[FAIL] %s %s: expected x%0d, actual x%0d", test_name, what, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %s %s: expected %b, actual %b", test_name, what, exp, act);
      value_errs++;
    end
  endtask

  // Encoders
  function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic word_t b_type(input logic [12:0] off, input reg_addr_t rs1,
                                   input reg_addr_t rs2, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic word_t j_type(input logic [20:0] off, input reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  task automatic emit(input word_t w);
    imem[wp] = w;
    wp++;
  endtask

  task automatic addi(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
    emit(i_type(imm, rs1, 3'b000, rd, OPC_OP_IMM));
  endtask

  // Unused words hold an unknown opcode that varies with the address
  task automatic new_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = {25'(i) ^ 25'h0a5_a5a5, 7'b111_1111};
    end
    wp = 0;
  endtask

  // ISA semantics for OP and OP_IMM
  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    logic [4:0] sh;
    word_t      fill;
    sh   = b[4:0];
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;  // Sign bits for SRA
    case (f3)
      3'b000:  alu_ref = alt ? a - b : a + b;
      3'b001:  alu_ref = a << sh;
      3'b010:  alu_ref = word_t'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
      3'b011:  alu_ref = word_t'(a < b);
      3'b100:  alu_ref = a ^ b;
      3'b101:  alu_ref = alt ? ((a >> sh) | fill) : (a >> sh);
      3'b110:  alu_ref = a | b;
      default: alu_ref = a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
    logic lts;
    lts = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (f3)
      3'b000:  branch_ref = (a == b);
      3'b001:  branch_ref = (a != b);
      3'b100:  branch_ref = lts;
      3'b101:  branch_ref = !lts;
      3'b110:  branch_ref = (a < b);
      default: branch_ref = !(a < b);
    endcase
  endfunction

  // Steps the reference model once and compares the retire trace
  task automatic check_commit(output logic stop, output logic exp_ill);
    word_t      w;
    word_t      a;
    word_t      b;
    word_t      data;
    word_t      npc;
    word_t      imm_i;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       we;
    logic       ill;
    w     = imem[mpc[7:2]];
    a     = mregs[w[19:15]];
    b     = mregs[w[24:20]];
    f3    = w[14:12];
    f7    = w[31:25];
    imm_i = {{20{w[31]}}, w[31:20]};
    we    = 1'b0;
    data  = '0;
    npc   = mpc + `INSN_BYTES;
    stop  = 1'b0;
    ill   = 1'b0;
    case (w[6:0])
      7'h33: begin
        if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) begin
          we   = 1'b1;
          data = alu_ref(f3, f7[5], a, b);
        end else begin
          ill = 1'b1;
        end
      end
      7'h13: begin
        if ((f3 == 3'b001 && f7 != 7'h00) ||
            (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20)) begin
          ill = 1'b1;
        end else begin
          we   = 1'b1;
          data = alu_ref(f3, f3 == 3'b101 && f7[5], a, imm_i);
        end
      end
      7'h37: begin
        we   = 1'b1;
        data = {w[31:12], 12'h000};
      end
      7'h17: begin
        we   = 1'b1;
        data = mpc + {w[31:12], 12'h000};
      end
      7'h63: begin
        if (f3 == 3'b010 || f3 == 3'b011) begin
          ill = 1'b1;
        end else if (branch_ref(f3, a, b)) begin
          npc = mpc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      7'h6f: begin
        we   = 1'b1;
        data = mpc + `INSN_BYTES;
        npc  = mpc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      7'h67: begin
        we   = 1'b1;
        data = mpc + `INSN_BYTES;
        npc  = (a + imm_i) & ~32'h1;
      end
      7'h0f: ;  // FENCE
      7'h73: begin
        if (w[31:7] == '0) stop = 1'b1;
        else ill = 1'b1;
      end
      default: ill = 1'b1;
    endcase
    check_word("commit_pc", mpc, commit_pc);
    check_flag("commit_we", we, commit_we);
    if (we) check_reg("commit_rd", w[11:7], commit_rd);
    check_word("commit_data", data, commit_data);
    if (we && w[11:7] != 5'd0) mregs[w[11:7]] = data;
    mpc     = npc;
    exp_ill = ill;
    stop    = stop || ill;
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    mpc = `RESET_PC;
  endtask

  // Runs the loaded program until the model sees it stop
  task automatic run_program(output int retired);
    logic stop;
    logic exp_ill;
    stop    = 1'b0;
    exp_ill = 1'b0;
    retired = 0;
    pulse_reset();
    while (!stop) begin
      @(negedge clk);
      if (commit_valid) begin
        check_flag("halt before stop", 1'b0, halt);
        check_commit(stop, exp_ill);
        retired++;
      end
    end
    @(negedge clk);
    if (commit_valid) retired++;
    check_flag("halt", 1'b1, halt);
    check_flag("illegal_insn", exp_ill, illegal_insn);
    repeat (20) begin
      @(negedge clk);
      check_flag("fetch_req after halt", 1'b0, fetch_req);
      if (commit_valid) retired++;  // Any retirement past the halt is extra
    end
    slow_src = 1'b0;
  endtask

  task automatic test_alu_imm();
    int n;
    test_name = "alu_imm";
    new_program();
    addi(1, 0, -5);
    addi(2, 0, 12'h7ff);
    emit(i_type(-4, 1, 3'b010, 3, OPC_OP_IMM));      // SLTI
    emit(i_type(-6, 1, 3'b010, 4, OPC_OP_IMM));
    emit(i_type(-1, 1, 3'b011, 5, OPC_OP_IMM));      // SLTIU
    emit(i_type(5, 2, 3'b011, 6, OPC_OP_IMM));
    emit(i_type(-1, 1, 3'b100, 7, OPC_OP_IMM));      // XORI
    emit(i_type(12'h555, 1, 3'b110, 8, OPC_OP_IMM));
    emit(i_type(12'h7f0, 1, 3'b111, 9, OPC_OP_IMM));
    emit(i_type(12'h01f, 2, 3'b001, 10, OPC_OP_IMM)); // SLLI by 31
    emit(i_type(12'h004, 1, 3'b101, 11, OPC_OP_IMM)); // SRLI
    emit(i_type(12'h404, 1, 3'b101, 12, OPC_OP_IMM)); // SRAI
    addi(0, 1, 100);  // Dropped write
    addi(13, 0, 7);
    emit(32'h0000_0073);
    run_program(n);
  endtask

  task automatic test_alu_reg();
    int n;
    test_name = "alu_reg";
    new_program();
    addi(1, 0, -7);
    addi(2, 0, 3);
    addi(3, 0, 35);  // Shifts see 3
    emit({20'h80000, 5'd4, OPC_LUI});
    emit(r_type(7'h00, 2, 1, 3'b000, 5));
    emit(r_type(7'h20, 1, 2, 3'b000, 6));
    emit(r_type(7'h00, 3, 1, 3'b001, 7));
    emit(r_type(7'h00, 2, 1, 3'b010, 8));
    emit(r_type(7'h00, 2, 1, 3'b011, 9));
    emit(r_type(7'h00, 2, 1, 3'b100, 10));
    emit(r_type(7'h00, 3, 4, 3'b101, 11));
    emit(r_type(7'h20, 3, 4, 3'b101, 12));
    emit(r_type(7'h00, 4, 1, 3'b110, 13));
    emit(r_type(7'h00, 2, 1, 3'b111, 14));
    emit({20'habcde, 5'd15, OPC_LUI});
    emit({20'h12345, 5'd16, OPC_AUIPC});
    emit(32'h0000_0073);
    run_program(n);
  endtask

  // Branch over one ADDI
  task automatic branch_pair(input logic [2:0] f3, input reg_addr_t a, input reg_addr_t b);
    emit(b_type(13'd8, a, b, f3));
    addi(9, 9, 1);
  endtask

  task automatic test_branches();
    int n;
    test_name = "branches";
    new_program();
    addi(1, 0, -1);
    addi(2, 0, 1);
    addi(3, 0, 1);
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        branch_pair(3'(f), 1, 2);
        branch_pair(3'(f), 2, 1);
        branch_pair(3'(f), 2, 3);
      end
    end
    addi(10, 0, 3);
    addi(10, 10, -1);
    emit(b_type(-13'sd4, 10, 0, 3'b001));  // Backward BNE
    emit(32'h0000_0073);
    run_program(n);
  endtask

  task automatic test_jumps();
    int n;
    test_name = "jumps";
    new_program();
    addi(1, 0, 17);
    emit(j_type(21'd12, 2));                      // To 16
    wp = 4;
    emit(i_type(12'd3, 1, 3'b000, 3, OPC_JALR));  // 17 + 3 with bit 0 already clear
    addi(4, 2, 0);
    emit(j_type(21'd8, 0));                       // To 32 with the link dropped
    wp = 8;
    addi(5, 0, 47);
    emit(i_type(-2, 5, 3'b000, 6, OPC_JALR));     // Odd sum 45 lands on 44
    wp = 11;
    emit(32'h0000_0073);
    run_program(n);
  endtask

  task automatic test_halt();
    int n;
    test_name = "ecall_fence";
    new_program();
    emit(i_type(12'h0ff, 0, 3'b000, 0, OPC_MISC_MEM));
    addi(1, 0, 9);
    emit(i_type(12'h0ff, 0, 3'b000, 0, OPC_MISC_MEM));
    addi(2, 1, 1);
    emit(32'h0000_0073);
    run_program(n);
    test_name = "illegal";
    new_program();
    addi(1, 0, 5);
    emit(32'h0000_500b);  // Custom-0 opcode
    addi(2, 0, 6);
    run_program(n);
  endtask

  task automatic test_slow_source();
    int n;
    test_name = "slow_source";
    new_program();
    for (int i = 1; i < 16; i++) begin
      addi(reg_addr_t'(i), reg_addr_t'(i - 1), 12'(i * 37));
    end
    emit(r_type(7'h00, 14, 15, 3'b000, 16));
    emit(r_type(7'h00, 3, 16, 3'b100, 17));
    emit(r_type(7'h20, 2, 17, 3'b101, 18));
    emit(32'h0000_0073);
    slow_src = 1'b1;
    run_program(n);
    check_word("retired count", word_t'(wp), word_t'(n));
  endtask

  initial begin
    rst        = 1'b1;
    lfsr       = 32'hee57;
    slow_src   = 1'b0;
    value_errs = 0;
    proto_errs = 0;
    test_name  = "init";
    test_alu_imm();
    test_alu_reg();
    test_branches();
    test_jumps();
    test_halt();
    test_slow_source();
    $display("Errors: %0d value mismatches, %0d handshake violations",
             value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
verilog/rv_pkg.sv
verilog/exec_if.sv
verilog/insn_decoder.sv
verilog/reg_file.sv
verilog/int_alu.sv
verilog/branch_unit.sv
verilog/sequencer.sv
verilog/rv_core.sv
testbench/tb_rv_core.sv
